// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Primary opcode field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same fetched word, R view and I view
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // Where an operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_XM,
        FWD_MW
    } fwd_sel_t;

    // Youngest in-flight writer of src wins
    function automatic fwd_sel_t fwd_pick(
        input isa_pkg::reg_addr_t src,
        input logic               xm_write,
        input isa_pkg::reg_addr_t xm_dest,
        input logic               mw_write,
        input isa_pkg::reg_addr_t mw_dest
    );
        if (src != '0 && xm_write && xm_dest == src) begin
            return FWD_XM;
        end
        if (src != '0 && mw_write && mw_dest == src) begin
            return FWD_MW;
        end
        return FWD_REG;
    endfunction

    function automatic isa_pkg::word_t fwd_mux(
        input fwd_sel_t       sel,
        input isa_pkg::word_t reg_data,
        input isa_pkg::word_t xm_data,
        input isa_pkg::word_t mw_data
    );
        case (sel)
            FWD_XM:  return xm_data;
            FWD_MW:  return mw_data;
            default: return reg_data;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/bypass_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bypass_if;

    // From the execute/memory register
    logic               xm_reg_write;
    logic               xm_mem_read;
    isa_pkg::reg_addr_t xm_dest;
    isa_pkg::word_t     xm_result;

    // After writeback selection, also the register file write port
    logic               mw_reg_write;
    isa_pkg::reg_addr_t mw_dest;
    isa_pkg::word_t     mw_data;

    modport xm_producer (output xm_reg_write, xm_mem_read, xm_dest, xm_result);

    modport mw_producer (output mw_reg_write, mw_dest, mw_data);

    modport consumer (
        input xm_reg_write, xm_mem_read, xm_dest, xm_result,
        input mw_reg_write, mw_dest, mw_data
    );

endinterface

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                     clock,
    input  wire                     reset,
    input  wire isa_pkg::reg_addr_t rd_addr_a,
    input  wire isa_pkg::reg_addr_t rd_addr_b,
    bypass_if.consumer              wr,
    output isa_pkg::word_t          rd_data_a,
    output isa_pkg::word_t          rd_data_b
);

    isa_pkg::word_t regs [32];
    logic           wr_en;

    assign wr_en = wr.mw_reg_write && (wr.mw_dest != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.mw_dest] <= wr.mw_data;
        end
    end

    // Write-through so decode sees this cycle's writeback
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr.mw_dest == addr) begin
            return wr.mw_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire isa_pkg::word_t inst,
    input  wire                 stall,
    input  wire                 branch_taken,
    input  wire isa_pkg::word_t branch_target,
    output isa_pkg::word_t      pc,
    output isa_pkg::instr_t     fd_instr,
    output isa_pkg::word_t      fd_pc_plus_4
);

    isa_pkg::word_t pc_plus_4;

    assign pc_plus_4 = pc + 32'd4;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc       <= RESET_PC;
            fd_instr <= isa_pkg::NOP_WORD;
        end else if (!stall) begin
            pc       <= branch_taken ? branch_target : pc_plus_4;
            fd_instr <= branch_taken ? isa_pkg::NOP_WORD : inst;  // Squash the slot
        end
    end

    // Only needed for the branch target
    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_plus_4 <= pc_plus_4;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     clock,
    input  wire                     reset,
    input  wire isa_pkg::instr_t    fd_instr,
    input  wire isa_pkg::word_t     fd_pc_plus_4,
    bypass_if.consumer              bp,
    output logic                    stall,
    output logic                    branch_taken,
    output isa_pkg::word_t          branch_target,
    output pipe_pkg::alu_op_t       dx_alu_op,
    output logic                    dx_use_imm,
    output logic                    dx_reg_write,
    output logic                    dx_mem_read,
    output logic                    dx_mem_write,
    output isa_pkg::reg_addr_t      dx_dest,
    output isa_pkg::reg_addr_t      dx_rs,
    output isa_pkg::reg_addr_t      dx_rt,
    output isa_pkg::word_t          dx_rs_data,
    output isa_pkg::word_t          dx_rt_data,
    output isa_pkg::word_t          dx_imm
);

    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::reg_addr_t dest;
    isa_pkg::word_t     imm_ext;
    isa_pkg::word_t     rf_rs_data;
    isa_pkg::word_t     rf_rt_data;
    isa_pkg::word_t     rs_val;
    isa_pkg::word_t     rt_val;
    pipe_pkg::fwd_sel_t rs_sel;
    pipe_pkg::fwd_sel_t rt_sel;
    pipe_pkg::alu_op_t  alu_op;
    logic               use_imm;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               is_beq;
    logic               uses_rt;
    logic               hit_x;
    logic               hit_m;

    assign rs      = fd_instr.r.rs;
    assign rt      = fd_instr.r.rt;
    assign imm_ext = {{16{fd_instr.i.imm[15]}}, fd_instr.i.imm};

    reg_file i_reg_file (
        .clock     (clock),
        .reset     (reset),
        .rd_addr_a (rs),
        .rd_addr_b (rt),
        .wr        (bp),
        .rd_data_a (rf_rs_data),
        .rd_data_b (rf_rt_data)
    );

    always_comb begin
        alu_op    = pipe_pkg::ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        uses_rt   = 1'b0;
        dest      = '0;
        case (fd_instr.r.opcode)
            isa_pkg::OP_RTYPE: begin
                dest      = fd_instr.r.rd;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (fd_instr.r.funct)
                    isa_pkg::FN_ADD: alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND: alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:  alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_SLT: alu_op = pipe_pkg::ALU_SLT;
                    default:         reg_write = 1'b0;  // NOP lands here
                endcase
            end
            isa_pkg::OP_ADDI: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest      = rt;
            end
            isa_pkg::OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                dest      = rt;
            end
            isa_pkg::OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                uses_rt   = 1'b1;  // Store data
            end
            isa_pkg::OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Branch compare sees the newest in-flight values
    assign rs_sel = pipe_pkg::fwd_pick(rs, bp.xm_reg_write, bp.xm_dest,
                                       bp.mw_reg_write, bp.mw_dest);
    assign rt_sel = pipe_pkg::fwd_pick(rt, bp.xm_reg_write, bp.xm_dest,
                                       bp.mw_reg_write, bp.mw_dest);
    assign rs_val = pipe_pkg::fwd_mux(rs_sel, rf_rs_data, bp.xm_result, bp.mw_data);
    assign rt_val = pipe_pkg::fwd_mux(rt_sel, rf_rt_data, bp.xm_result, bp.mw_data);

    // Source matches in execute and in memory
    assign hit_x = (dx_dest != '0) && (dx_dest == rs || (uses_rt && dx_dest == rt));
    assign hit_m = (bp.xm_dest != '0) && (bp.xm_dest == rs || (uses_rt && bp.xm_dest == rt));

    // Load-use, branch on execute result, branch on load in memory
    assign stall = (dx_mem_read && hit_x)
                || (is_beq && dx_reg_write && hit_x)
                || (is_beq && bp.xm_mem_read && hit_m);

    assign branch_taken  = is_beq && (rs_val == rt_val) && !stall;
    assign branch_target = fd_pc_plus_4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dx_alu_op    <= pipe_pkg::ALU_ADD;
            dx_use_imm   <= 1'b0;
            dx_reg_write <= 1'b0;
            dx_mem_read  <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_dest      <= '0;
            dx_rs        <= '0;
            dx_rt        <= '0;
        end else if (stall) begin
            dx_reg_write <= 1'b0;  // Bubble
            dx_mem_read  <= 1'b0;
            dx_mem_write <= 1'b0;
            dx_dest      <= '0;
            dx_rs        <= '0;
            dx_rt        <= '0;
        end else begin
            dx_alu_op    <= alu_op;
            dx_use_imm   <= use_imm;
            dx_reg_write <= reg_write;
            dx_mem_read  <= mem_read;
            dx_mem_write <= mem_write;
            dx_dest      <= dest;
            dx_rs        <= rs;
            dx_rt        <= rt;
        end
    end

    // Execute forwarding covers anything newer than the register file
    always_ff @(posedge clock) begin
        dx_rs_data <= rf_rs_data;
        dx_rt_data <= rf_rt_data;
        dx_imm     <= imm_ext;
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     clock,
    input  wire                     reset,
    input  wire pipe_pkg::alu_op_t  dx_alu_op,
    input  wire                     dx_use_imm,
    input  wire                     dx_reg_write,
    input  wire                     dx_mem_read,
    input  wire                     dx_mem_write,
    input  wire isa_pkg::reg_addr_t dx_dest,
    input  wire isa_pkg::reg_addr_t dx_rs,
    input  wire isa_pkg::reg_addr_t dx_rt,
    input  wire isa_pkg::word_t     dx_rs_data,
    input  wire isa_pkg::word_t     dx_rt_data,
    input  wire isa_pkg::word_t     dx_imm,
    bypass_if.consumer              bp,
    bypass_if.xm_producer           xm,
    output isa_pkg::word_t          xm_store_data,
    output logic                    xm_mem_write
);

    pipe_pkg::fwd_sel_t rs_sel;
    pipe_pkg::fwd_sel_t rt_sel;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     rt_val;
    isa_pkg::word_t     result;

    assign rs_sel = pipe_pkg::fwd_pick(dx_rs, bp.xm_reg_write, bp.xm_dest,
                                       bp.mw_reg_write, bp.mw_dest);
    assign rt_sel = pipe_pkg::fwd_pick(dx_rt, bp.xm_reg_write, bp.xm_dest,
                                       bp.mw_reg_write, bp.mw_dest);

    assign op_a   = pipe_pkg::fwd_mux(rs_sel, dx_rs_data, bp.xm_result, bp.mw_data);
    assign rt_val = pipe_pkg::fwd_mux(rt_sel, dx_rt_data, bp.xm_result, bp.mw_data);
    assign op_b   = dx_use_imm ? dx_imm : rt_val;  // rt_val doubles as store data

    always_comb begin
        case (dx_alu_op)
            pipe_pkg::ALU_SUB: result = op_a - op_b;
            pipe_pkg::ALU_AND: result = op_a & op_b;
            pipe_pkg::ALU_OR:  result = op_a | op_b;
            pipe_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:           result = op_a + op_b;  // Also address generation
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            xm.xm_reg_write <= 1'b0;
            xm.xm_mem_read  <= 1'b0;
            xm.xm_dest      <= '0;
            xm_mem_write    <= 1'b0;
        end else begin
            xm.xm_reg_write <= dx_reg_write;
            xm.xm_mem_read  <= dx_mem_read;
            xm.xm_dest      <= dx_dest;
            xm_mem_write    <= dx_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        xm.xm_result  <= result;
        xm_store_data <= rt_val;
    end

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  wire                 clock,
    input  wire                 reset,
    bypass_if.consumer          bp,
    input  wire isa_pkg::word_t xm_store_data,
    input  wire                 xm_mem_write,
    input  wire isa_pkg::word_t dout,
    output logic                mem_read,
    output logic                mem_write,
    output isa_pkg::word_t      addr,
    output isa_pkg::word_t      din,
    bypass_if.mw_producer       mw
);

    logic           mw_is_load;
    isa_pkg::word_t mw_load_data;
    isa_pkg::word_t mw_alu_result;

    // Single-cycle strobes straight from the execute/memory register
    assign mem_read  = bp.xm_mem_read;
    assign mem_write = xm_mem_write;
    assign addr      = bp.xm_result;
    assign din       = xm_store_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mw.mw_reg_write <= 1'b0;
            mw.mw_dest      <= '0;
            mw_is_load      <= 1'b0;
        end else begin
            mw.mw_reg_write <= bp.xm_reg_write;
            mw.mw_dest      <= bp.xm_dest;
            mw_is_load      <= bp.xm_mem_read;
        end
    end

    always_ff @(posedge clock) begin
        mw_load_data  <= dout;  // Valid by this edge when mem_read is high
        mw_alu_result <= bp.xm_result;
    end

    assign mw.mw_data = mw_is_load ? mw_load_data : mw_alu_result;

endmodule

`default_nettype wire

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                 clock,
    input  wire                 reset,
    output isa_pkg::word_t      pc,
    input  wire isa_pkg::word_t inst,
    output logic                mem_read,
    output logic                mem_write,
    output isa_pkg::word_t      addr,
    output isa_pkg::word_t      din,
    input  wire isa_pkg::word_t dout
);

    logic               stall;
    logic               branch_taken;
    isa_pkg::word_t     branch_target;
    isa_pkg::instr_t    fd_instr;
    isa_pkg::word_t     fd_pc_plus_4;
    pipe_pkg::alu_op_t  dx_alu_op;
    logic               dx_use_imm;
    logic               dx_reg_write;
    logic               dx_mem_read;
    logic               dx_mem_write;
    isa_pkg::reg_addr_t dx_dest;
    isa_pkg::reg_addr_t dx_rs;
    isa_pkg::reg_addr_t dx_rt;
    isa_pkg::word_t     dx_rs_data;
    isa_pkg::word_t     dx_rt_data;
    isa_pkg::word_t     dx_imm;
    isa_pkg::word_t     xm_store_data;
    logic               xm_mem_write;

    bypass_if bp ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clock         (clock),
        .reset         (reset),
        .inst          (inst),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .fd_instr      (fd_instr),
        .fd_pc_plus_4  (fd_pc_plus_4)
    );

    decode_stage i_decode (
        .clock         (clock),
        .reset         (reset),
        .fd_instr      (fd_instr),
        .fd_pc_plus_4  (fd_pc_plus_4),
        .bp            (bp),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .dx_alu_op     (dx_alu_op),
        .dx_use_imm    (dx_use_imm),
        .dx_reg_write  (dx_reg_write),
        .dx_mem_read   (dx_mem_read),
        .dx_mem_write  (dx_mem_write),
        .dx_dest       (dx_dest),
        .dx_rs         (dx_rs),
        .dx_rt         (dx_rt),
        .dx_rs_data    (dx_rs_data),
        .dx_rt_data    (dx_rt_data),
        .dx_imm        (dx_imm)
    );

    execute_stage i_execute (
        .clock         (clock),
        .reset         (reset),
        .dx_alu_op     (dx_alu_op),
        .dx_use_imm    (dx_use_imm),
        .dx_reg_write  (dx_reg_write),
        .dx_mem_read   (dx_mem_read),
        .dx_mem_write  (dx_mem_write),
        .dx_dest       (dx_dest),
        .dx_rs         (dx_rs),
        .dx_rt         (dx_rt),
        .dx_rs_data    (dx_rs_data),
        .dx_rt_data    (dx_rt_data),
        .dx_imm        (dx_imm),
        .bp            (bp),
        .xm            (bp),
        .xm_store_data (xm_store_data),
        .xm_mem_write  (xm_mem_write)
    );

    mem_wb_stage i_mem_wb (
        .clock         (clock),
        .reset         (reset),
        .bp            (bp),
        .xm_store_data (xm_store_data),
        .xm_mem_write  (xm_mem_write),
        .dout          (dout),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .addr          (addr),
        .din           (din),
        .mw            (bp)
    );

endmodule

`default_nettype wire

// ==== verif/mips_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_sva (
    input wire                 clock,
    input wire                 reset,
    input wire isa_pkg::word_t pc,
    input wire                 mem_read,
    input wire                 mem_write
);

    // Data port never reads and writes in the same cycle
    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write high together");

    a_idle_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (!mem_read && !mem_write)
    ) else $error("Memory strobe active in the first cycle after reset");

    // Word-aligned fetch
    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("pc not a multiple of 4: %h", pc);

endmodule

bind mips_core mips_core_sva i_sva (
    .clock     (clock),
    .reset     (reset),
    .pc        (pc),
    .mem_read  (mem_read),
    .mem_write (mem_write)
);

`default_nettype wire

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam isa_pkg::word_t RESET_PC = 32'h0000_0080;
    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = 32;
    localparam int PC_STEPS     = 8;
    // One extra cycle per test before reset goes high
    localparam int RESET_TEST_LEN = RESET_CYCLES + 1 + PC_STEPS;
    localparam int PROG_TEST_LEN  = RESET_CYCLES + 1 + RUN_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_TEST_LEN + 5 * PROG_TEST_LEN + 50;

    logic           clock;
    logic           reset;
    isa_pkg::word_t inst;
    isa_pkg::word_t dout;
    isa_pkg::word_t pc;
    logic           mem_read;
    logic           mem_write;
    isa_pkg::word_t addr;
    isa_pkg::word_t din;

    isa_pkg::word_t imem [64];
    isa_pkg::word_t dmem [64];
    isa_pkg::word_t prog [$];   // Program for the next test
    logic           wr_pending;
    isa_pkg::word_t wr_addr;
    isa_pkg::word_t wr_data;
    integer         seed;
    int             cycles;

    mips_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .pc        (pc),
        .inst      (inst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .addr      (addr),
        .din       (din),
        .dout      (dout)
    );

    always #50 clock = ~clock;

    // Memories read and sample the DUT on the falling edge
    always @(negedge clock) begin
        inst       = imem[pc[7:2]];
        dout       = mem_read ? dmem[addr[7:2]] : '0;  // Read data only on a read strobe
        wr_pending = mem_write;
        wr_addr    = addr;
        wr_data    = din;
    end

    always @(posedge clock) begin
        if (wr_pending) begin
            dmem[wr_addr[7:2]] = wr_data;  // Store lands at the rising edge
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d clock cycles", cycles);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    function automatic isa_pkg::word_t r_type(
        input isa_pkg::funct_t    fn,
        input isa_pkg::reg_addr_t rd,
        input isa_pkg::reg_addr_t rs,
        input isa_pkg::reg_addr_t rt
    );
        return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic isa_pkg::word_t i_type(
        input isa_pkg::opcode_t   op,
        input isa_pkg::reg_addr_t rt,
        input isa_pkg::reg_addr_t rs,
        input logic [15:0]        imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t sign_extend(input logic signed [15:0] value);
        return 32'(value);
    endfunction

    // Background data differs at every byte address
    function automatic isa_pkg::word_t fill_word(input isa_pkg::word_t byte_addr);
        return 32'hc0de_0000 ^ byte_addr;
    endfunction

    function automatic isa_pkg::word_t data_at(input isa_pkg::word_t byte_addr);
        return dmem[byte_addr[7:2]];
    endfunction

    task automatic preset_data(input isa_pkg::word_t byte_addr, input isa_pkg::word_t value);
        dmem[byte_addr[7:2]] = value;
    endtask

    task automatic load_program;
        logic [5:0] slot;
        for (int i = 0; i < 64; i++) begin
            slot       = 6'(i);
            imem[slot] = isa_pkg::NOP_WORD;
            dmem[slot] = fill_word({24'd0, slot, 2'b00});
        end
        foreach (prog[k]) begin
            slot       = RESET_PC[7:2] + 6'(k);
            imem[slot] = prog[k];
        end
    endtask

    task automatic reset_dut;
        @(negedge clock);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic check_word(
        input string          name,
        input isa_pkg::word_t expected,
        input isa_pkg::word_t actual
    );
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_pc(
        input string          name,
        input isa_pkg::word_t expected,
        input isa_pkg::word_t actual
    );
        if (actual !== expected) begin
            $display("** Error %s: expected pc %h, actual pc %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic pc_after_reset;
        prog.delete();
        load_program();
        reset_dut();
        check_pc("pc_after_reset start", RESET_PC, pc);
        check_flag("pc_after_reset mem_read", 1'b0, mem_read);
        check_flag("pc_after_reset mem_write", 1'b0, mem_write);
        for (int k = 1; k <= PC_STEPS; k++) begin
            @(negedge clock);
            check_pc("pc_after_reset step", RESET_PC + 32'(4 * k), pc);
        end
    endtask

    task automatic alu_chain;
        logic [15:0]    imm_a;
        logic [15:0]    imm_b;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t sum;
        isa_pkg::word_t diff;
        isa_pkg::word_t and_v;
        isa_pkg::word_t or_v;
        isa_pkg::word_t lt_or_b;
        isa_pkg::word_t lt_b_or;
        imm_a   = 16'($random(seed));
        imm_b   = 16'($random(seed));
        a       = sign_extend(imm_a);
        b       = sign_extend(imm_b);
        sum     = a + b;
        diff    = sum - b;
        and_v   = diff & sum;
        or_v    = and_v | a;
        lt_or_b = {31'd0, $signed(or_v) < $signed(b)};
        lt_b_or = {31'd0, $signed(b) < $signed(or_v)};
        prog.delete();
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, imm_a));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd2, 5'd0, imm_b));
        prog.push_back(r_type(isa_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
        prog.push_back(r_type(isa_pkg::FN_SUB, 5'd4, 5'd3, 5'd2));
        prog.push_back(r_type(isa_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(r_type(isa_pkg::FN_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(r_type(isa_pkg::FN_SLT, 5'd7, 5'd6, 5'd2));
        prog.push_back(r_type(isa_pkg::FN_SLT, 5'd8, 5'd2, 5'd6));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd8, 5'd0, 16'h0024));  // Store data from XM
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd7, 5'd0, 16'h0020));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd6, 5'd0, 16'h001c));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd5, 5'd0, 16'h0018));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd4, 5'd0, 16'h0014));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0010));
        load_program();
        reset_dut();
        repeat (RUN_CYCLES) @(negedge clock);
        check_word("alu_chain add", sum, data_at(32'h10));
        check_word("alu_chain sub", diff, data_at(32'h14));
        check_word("alu_chain and", and_v, data_at(32'h18));
        check_word("alu_chain or", or_v, data_at(32'h1c));
        check_word("alu_chain slt", lt_or_b, data_at(32'h20));
        check_word("alu_chain slt swapped", lt_b_or, data_at(32'h24));
    endtask

    task automatic addi_negative;
        logic [15:0]    imm_n;
        isa_pkg::word_t expected;
        imm_n    = 16'($random(seed)) | 16'h8000;
        expected = 32'h0000_1234 + sign_extend(imm_n);
        prog.delete();
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd2, 5'd1, imm_n));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd3, 5'd0, 16'h8000));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0007));  // Discarded
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd0, 5'd0, 16'h0048));
        prog.push_back(r_type(isa_pkg::FN_ADD, 5'd4, 5'd0, 5'd3));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd2, 5'd0, 16'h0040));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0044));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd4, 5'd0, 16'h004c));
        load_program();
        reset_dut();
        repeat (RUN_CYCLES) @(negedge clock);
        check_word("addi_negative sum", expected, data_at(32'h40));
        check_word("addi_negative from zero", sign_extend(16'h8000), data_at(32'h44));
        check_word("addi_negative r0 store", 32'h0, data_at(32'h48));
        check_word("addi_negative r0 operand", sign_extend(16'h8000), data_at(32'h4c));
    endtask

    task automatic load_then_use;
        logic [15:0]    imm_c;
        isa_pkg::word_t ld_a;
        isa_pkg::word_t ld_b;
        imm_c = 16'($random(seed));
        ld_a  = 32'($random(seed));
        ld_b  = 32'($random(seed));
        prog.delete();
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, imm_c));
        prog.push_back(i_type(isa_pkg::OP_LW, 5'd2, 5'd0, 16'h0050));
        prog.push_back(r_type(isa_pkg::FN_ADD, 5'd3, 5'd2, 5'd1));  // Uses the load at once
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0054));
        prog.push_back(i_type(isa_pkg::OP_LW, 5'd4, 5'd0, 16'h0058));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd4, 5'd0, 16'h005c));
        load_program();
        preset_data(32'h50, ld_a);
        preset_data(32'h58, ld_b);
        reset_dut();
        repeat (RUN_CYCLES) @(negedge clock);
        check_word("load_then_use add", ld_a + sign_extend(imm_c), data_at(32'h54));
        check_word("load_then_use copy", ld_b, data_at(32'h5c));
    endtask

    task automatic beq_taken;
        logic [15:0] imm_v;
        imm_v = 16'($random(seed));
        prog.delete();
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0007));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'h0007));
        prog.push_back(i_type(isa_pkg::OP_BEQ, 5'd2, 5'd1, 16'h0003));  // To index 6
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0060));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0064));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0068));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd2, 5'd0, 16'h006c));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd4, 5'd0, imm_v));
        prog.push_back(i_type(isa_pkg::OP_LW, 5'd3, 5'd0, 16'h0070));
        prog.push_back(i_type(isa_pkg::OP_BEQ, 5'd4, 5'd3, 16'h0001));  // Waits on the load
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd4, 5'd0, 16'h0074));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd3, 5'd0, 16'h0078));
        load_program();
        preset_data(32'h70, sign_extend(imm_v));
        reset_dut();
        repeat (RUN_CYCLES) @(negedge clock);
        check_word("beq_taken slot", fill_word(32'h60), data_at(32'h60));
        check_word("beq_taken skipped", fill_word(32'h64), data_at(32'h64));
        check_word("beq_taken skipped", fill_word(32'h68), data_at(32'h68));
        check_word("beq_taken target", 32'd7, data_at(32'h6c));
        check_word("beq_taken load slot", fill_word(32'h74), data_at(32'h74));
        check_word("beq_taken load target", sign_extend(imm_v), data_at(32'h78));
    endtask

    task automatic beq_not_taken;
        prog.delete();
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0005));
        prog.push_back(i_type(isa_pkg::OP_BEQ, 5'd0, 5'd1, 16'h0002));  // Stale r1 would take it
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0080));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd1, 5'd0, 16'h0084));
        prog.push_back(i_type(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'h0009));
        prog.push_back(i_type(isa_pkg::OP_SW, 5'd2, 5'd0, 16'h0088));
        load_program();
        reset_dut();
        repeat (RUN_CYCLES) @(negedge clock);
        check_word("beq_not_taken slot", 32'd5, data_at(32'h80));
        check_word("beq_not_taken fall through", 32'd5, data_at(32'h84));
        check_word("beq_not_taken after", 32'd9, data_at(32'h88));
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        inst       = isa_pkg::NOP_WORD;
        dout       = '0;
        wr_pending = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        seed       = 5242;
        cycles     = 0;
        pc_after_reset();
        alu_chain();
        addi_negative();
        load_then_use();
        beq_taken();
        beq_not_taken();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/bypass_if.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/mips_core.sv
verif/mips_core_sva.sv
verif/tb_mips_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips_core -f sources.f -o tb_mips_core_sim \
    && ./obj_dir/tb_mips_core_sim \
    || { echo "Simulation run did not complete successfully"; exit 1; }
